/* source/risc621Pkg.sv */
package risc621Pkg;

	// ----------------------------------------
	// Widths that carry a meaning
	// ----------------------------------------
	typedef logic [11:0] word_t;        // Data and instruction word
	typedef logic [1:0]  regIndex_t;    // One of four registers
	typedef logic [3:0]  flags_t;       // C N V Z
	typedef logic [1:0]  shiftAmount_t; // k field of the instruction

	// Bit positions inside flags_t
	parameter int flagC = 3;
	parameter int flagN = 2;
	parameter int flagV = 1;
	parameter int flagZ = 0;

	// ----------------------------------------
	// Opcodes, IR[11:6]
	// ----------------------------------------
	typedef enum logic [5:0] {
		NOP  = 6'b000000,
		LD   = 6'b000001, // ri <- M[R[rj] + k]
		ST   = 6'b000010, // M[R[rj] + k] <- ri
		CPY  = 6'b000011, // ri <- rj
		JMP  = 6'b010000, // Conditional, target in R[k]
		ADD  = 6'b100000,
		SUB  = 6'b100001,
		ADDC = 6'b100010, // Constant k as second operand
		SUBC = 6'b100011,
		NOT  = 6'b101000,
		AND  = 6'b101001,
		OR   = 6'b101010,
		XOR  = 6'b101011,
		SHLL = 6'b101100,
		SHRL = 6'b101101,
		SHLA = 6'b101110, // Sign bit held
		SHRA = 6'b101111,
		ROTL = 6'b110000,
		ROTR = 6'b110001
	} opcode_t;

	// Jump conditions, IR[5:2] of a JMP
	typedef enum logic [3:0] {
		JU  = 4'b0000, // Always
		JC1 = 4'b1000,
		JN1 = 4'b0100,
		JV1 = 4'b0010,
		JZ1 = 4'b0001,
		JC0 = 4'b0111,
		JN0 = 4'b1011,
		JV0 = 4'b1101,
		JZ0 = 4'b1110
	} jumpCond_t;

	// Four machine cycles per instruction
	typedef enum logic [1:0] {
		FETCH     = 2'b00,
		DECODE    = 2'b01,
		EXECUTE   = 2'b10,
		WRITEBACK = 2'b11
	} machineCycle_t;

	// Top byte of an address in the I/O page, 0xFF0 to 0xFFF
	parameter logic [7:0] ioPagePrefix = 8'hFF;

endpackage

/* source/programMemory.sv */
`timescale 1ns/1ps

module programMemory
	import risc621Pkg::*;
#(
	parameter int ProgramDepth = 256
)
(
	input  logic  Clock_pin,
	input  word_t fetchAddr,
	output word_t instr,
	input  logic  loadWrite,
	input  word_t loadAddr,
	input  word_t loadData
);

	localparam int AddrBits = $clog2(ProgramDepth);

	word_t mem [ProgramDepth]; // Instruction store

	// Load port and registered fetch share one clock
	always_ff @(posedge Clock_pin)
	begin
		if (loadWrite)
			mem[loadAddr[AddrBits-1:0]] <= loadData;
		instr <= mem[fetchAddr[AddrBits-1:0]]; // Valid one cycle later, in DECODE
	end

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ps

module registerFile
	import risc621Pkg::*;
(
	input  logic      Clock_pin,
	input  logic      rstN,
	input  regIndex_t readIndexA,
	input  regIndex_t readIndexB,
	input  regIndex_t writeIndex,
	input  logic      writeEnable,
	input  word_t     writeData,
	output word_t     readDataA,
	output word_t     readDataB
);

	word_t regs [4]; // R0..R3

	// Combinational reads
	assign readDataA = regs[readIndexA];
	assign readDataB = regs[readIndexB];

	always_ff @(posedge Clock_pin or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
			regs[writeIndex] <= writeData; // Only in WRITEBACK
	end

	// A write must carry a defined ALU result or load word
	writeDataKnown: assert property (@(posedge Clock_pin) disable iff (!rstN)
		writeEnable |-> !$isunknown(writeData))
		else $error("registerFile: unknown write data to R%0d", writeIndex);

endmodule

/* source/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory
	import risc621Pkg::*;
#(
	parameter int DataDepth = 256
)
(
	input  logic       Clock_pin,
	input  logic       rstN,
	input  word_t      memAddr,
	input  word_t      storeData,
	input  logic       memWrite,
	input  logic       memRead,
	input  logic [4:0] switches,
	output word_t      loadData,
	output logic [7:0] display
);

	localparam int AddrBits = $clog2(DataDepth);

	word_t               ram [DataDepth];
	logic                isIo;     // Address in 0xFF0..0xFFF
	logic                ramWe;
	logic [AddrBits-1:0] ramIndex; // Low address bits only

	assign isIo     = (memAddr[11:4] == ioPagePrefix);
	assign ramWe    = memWrite && !isIo;
	assign ramIndex = memAddr[AddrBits-1:0];

	// ----------------------------------------
	// RAM and load path
	// ----------------------------------------
	always_ff @(posedge Clock_pin)
	begin
		if (ramWe)
			ram[ramIndex] <= storeData; // End of WRITEBACK
		if (memRead)
			loadData <= isIo ? {7'b0, switches} : ram[ramIndex]; // End of EXECUTE
	end

	// Display port, low byte of a store to the I/O page
	always_ff @(posedge Clock_pin or negedge rstN)
	begin
		if (!rstN)
			display <= '0;
		else if (memWrite && isIo)
			display <= storeData[7:0];
	end

	// A store to the I/O page leaves the aliased RAM word alone
	ioNeverInRam: assert property (@(posedge Clock_pin) disable iff (!rstN)
		memWrite && isIo |=> ram[$past(ramIndex)] === $past(ram[ramIndex]))
		else $error("dataMemory: RAM written by I/O store to %h", $past(memAddr));

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
	import risc621Pkg::*;
(
	input  logic         Clock_pin,
	input  logic         rstN,
	input  opcode_t      opcode,
	input  word_t        operandA,
	input  word_t        operandB,
	input  shiftAmount_t shiftAmount,
	input  logic         latchOperands,
	input  logic         executeStrobe,
	input  logic         commitFlags,
	output word_t        result,
	output flags_t       flags
);

	word_t        opA;        // Latched at end of DECODE
	word_t        opB;
	shiftAmount_t k;
	word_t        addOperand; // rj or constant k
	logic [12:0]  sum;
	logic [12:0]  diff;
	logic [10:0]  shlaLow;
	logic [23:0]  rotlWide;
	logic [23:0]  rotrWide;
	word_t        nextResult;
	flags_t       nextFlags;
	flags_t       tempFlags;
	logic         setsNz;

	always_ff @(posedge Clock_pin)
	begin
		if (latchOperands)
		begin
			opA <= operandA;
			opB <= operandB;
			k   <= shiftAmount;
		end
	end

	// ----------------------------------------
	// Datapath
	// ----------------------------------------
	assign addOperand = (opcode == ADDC || opcode == SUBC) ? {10'b0, k} : opB;
	assign sum        = {1'b0, opA} + {1'b0, addOperand};
	assign diff       = {1'b0, opA} - {1'b0, addOperand}; // Bit 12 is the borrow
	assign shlaLow    = opA[10:0] << k;
	assign rotlWide   = {opA, opA} << k;
	assign rotrWide   = {opA, opA} >> k;

	always_comb
	begin
		nextResult = opA;
		nextFlags  = flags; // Unchanged unless set below
		setsNz     = 1'b0;
		case (opcode)
			ADD, ADDC:
			begin
				nextResult       = sum[11:0];
				nextFlags[flagC] = sum[12];
				nextFlags[flagV] = (opA[11] == addOperand[11]) && (sum[11] != opA[11]);
				setsNz           = 1'b1;
			end
			SUB, SUBC:
			begin
				nextResult       = diff[11:0];
				nextFlags[flagC] = diff[12];
				nextFlags[flagV] = (opA[11] != addOperand[11]) && (diff[11] != opA[11]);
				setsNz           = 1'b1;
			end
			NOT: begin nextResult = ~opA;       setsNz = 1'b1; end
			AND: begin nextResult = opA & opB;  setsNz = 1'b1; end
			OR:  begin nextResult = opA | opB;  setsNz = 1'b1; end
			XOR: begin nextResult = opA ^ opB;  setsNz = 1'b1; end
			SHLL: nextResult = opA << k;
			SHRL: nextResult = opA >> k;
			SHLA: nextResult = {opA[11], shlaLow}; // Sign stays put
			SHRA: nextResult = word_t'($signed(opA) >>> k);
			ROTL: nextResult = rotlWide[23:12];
			ROTR: nextResult = rotrWide[11:0];
			CPY:  nextResult = opB;
			default: nextResult = opA; // Memory ops and NOP
		endcase
		if (setsNz)
		begin
			nextFlags[flagN] = nextResult[11];
			nextFlags[flagZ] = (nextResult == '0);
		end
	end

	// Result register, end of EXECUTE
	always_ff @(posedge Clock_pin)
	begin
		if (executeStrobe)
			result <= nextResult;
	end

	// Temporary then committed flags
	always_ff @(posedge Clock_pin or negedge rstN)
	begin
		if (!rstN)
		begin
			tempFlags <= '0;
			flags     <= '0;
		end
		else
		begin
			if (executeStrobe)
				tempFlags <= nextFlags;
			if (commitFlags)
				flags <= tempFlags; // End of WRITEBACK
		end
	end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
	import risc621Pkg::*;
(
	input  logic      Clock_pin,
	input  logic      rstN,
	input  word_t     instr,
	input  word_t     readDataA,
	input  word_t     readDataB,
	input  flags_t    flags,
	input  word_t     loadData,
	output word_t     pc,
	output regIndex_t readIndexA,
	output regIndex_t readIndexB,
	output regIndex_t writeIndex,
	output logic      regWrite,
	output logic      writeSelect, // 1 picks loadData
	output opcode_t   opcode,
	output logic      latchOperands,
	output logic      executeStrobe,
	output logic      commitFlags,
	output word_t     memAddr,
	output logic      memWrite,
	output logic      memRead
);

	machineCycle_t cycle;
	word_t         ir;       // Held from end of DECODE
	word_t         activeIr; // Fresh word while in DECODE
	word_t         effAddr;
	word_t         eaReg;    // Address kept for WRITEBACK
	regIndex_t     ri;
	regIndex_t     rj;
	shiftAmount_t  k;
	jumpCond_t     cond;
	logic          jumpTaken;
	logic          isArith;
	logic          isLogic;
	logic          isShift;
	logic          isCopy;
	logic          isLoad;
	logic          isStore;
	logic          isJump;

	// ----------------------------------------
	// Field decode
	// ----------------------------------------
	assign activeIr = (cycle == DECODE) ? instr : ir;
	assign opcode   = opcode_t'(activeIr[11:6]);
	assign ri       = activeIr[5:4];
	assign rj       = activeIr[3:2];
	assign k        = activeIr[1:0];
	assign cond     = jumpCond_t'(activeIr[5:2]);

	always_comb
	begin
		isArith = 1'b0;
		isLogic = 1'b0;
		isShift = 1'b0;
		isCopy  = 1'b0;
		isLoad  = 1'b0;
		isStore = 1'b0;
		isJump  = 1'b0;
		case (opcode)
			ADD, SUB, ADDC, SUBC:                   isArith = 1'b1;
			NOT, AND, OR, XOR:                      isLogic = 1'b1;
			SHLL, SHRL, SHLA, SHRA, ROTL, ROTR:     isShift = 1'b1;
			CPY:                                    isCopy  = 1'b1;
			LD:                                     isLoad  = 1'b1;
			ST:                                     isStore = 1'b1;
			JMP:                                    isJump  = 1'b1;
			default:                                isArith = 1'b0; // NOP
		endcase
	end

	// Port A gives the address base in EXECUTE, port B the jump target or store data later
	assign readIndexA = (cycle == EXECUTE) ? rj : ri;
	assign readIndexB = (cycle == WRITEBACK) ? (isJump ? k : ri) : rj;

	assign effAddr = readDataA + {10'b0, k};
	assign memAddr = (cycle == EXECUTE) ? effAddr : eaReg;

	// Strobes, one cycle each
	assign latchOperands = (cycle == DECODE);
	assign executeStrobe = (cycle == EXECUTE);
	assign memRead       = (cycle == EXECUTE) && isLoad;
	assign memWrite      = (cycle == WRITEBACK) && isStore;
	assign regWrite      = (cycle == WRITEBACK)
		&& (isArith || isLogic || isShift || isCopy || isLoad);
	assign commitFlags   = (cycle == WRITEBACK) && (isArith || isLogic);
	assign writeSelect   = isLoad;
	assign writeIndex    = ri;

	// Jump decision on committed flags
	always_comb
	begin
		case (cond)
			JU:      jumpTaken = 1'b1;
			JC1:     jumpTaken = flags[flagC];
			JN1:     jumpTaken = flags[flagN];
			JV1:     jumpTaken = flags[flagV];
			JZ1:     jumpTaken = flags[flagZ];
			JC0:     jumpTaken = !flags[flagC];
			JN0:     jumpTaken = !flags[flagN];
			JV0:     jumpTaken = !flags[flagV];
			JZ0:     jumpTaken = !flags[flagZ];
			default: jumpTaken = 1'b0; // Unused codes fall through
		endcase
	end

	// ----------------------------------------
	// Sequencer and PC
	// ----------------------------------------
	always_ff @(posedge Clock_pin or negedge rstN)
	begin
		if (!rstN)
		begin
			cycle <= FETCH;
			pc    <= '0;
		end
		else
		begin
			case (cycle)
				FETCH:
				begin
					pc    <= pc + 12'd1;
					cycle <= DECODE;
				end
				DECODE:  cycle <= EXECUTE;
				EXECUTE: cycle <= WRITEBACK;
				default:
				begin
					if (isJump && jumpTaken)
						pc <= readDataB; // Absolute target R[k]
					cycle <= FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge Clock_pin)
	begin
		if (cycle == DECODE)
			ir <= instr;
		if (cycle == EXECUTE)
			eaReg <= effAddr;
	end

	cycleAdvances: assert property (@(posedge Clock_pin) disable iff (!rstN)
		$past(rstN) |-> cycle != $past(cycle))
		else $error("controlUnit: machine cycle stalled at %s", cycle.name());

endmodule

/* source/risc621.sv */
`timescale 1ns/1ps

module risc621
	import risc621Pkg::*;
#(
	parameter int ProgramDepth = 256,
	parameter int DataDepth    = 256
)
(
	input  logic       Clock_pin,
	input  logic       rstN,
	input  logic [4:0] switches,
	output logic [7:0] display,
	input  logic       progWrite,
	input  word_t      progAddr,
	input  word_t      progData
);

	word_t     pc;
	word_t     instr;
	regIndex_t readIndexA;
	regIndex_t readIndexB;
	regIndex_t writeIndex;
	word_t     readDataA;
	word_t     readDataB;
	word_t     writeData;
	logic      regWrite;
	logic      writeSelect;
	opcode_t   opcode;
	logic      latchOperands;
	logic      executeStrobe;
	logic      commitFlags;
	word_t     result;
	flags_t    flags;
	word_t     memAddr;
	logic      memWrite;
	logic      memRead;
	word_t     loadData;

	// Register write source, load word or ALU result
	assign writeData = writeSelect ? loadData : result;

	controlUnit u_controlUnit (
		.Clock_pin(Clock_pin), .rstN(rstN),
		.instr(instr), .readDataA(readDataA), .readDataB(readDataB),
		.flags(flags), .loadData(loadData), .pc(pc),
		.readIndexA(readIndexA), .readIndexB(readIndexB), .writeIndex(writeIndex),
		.regWrite(regWrite), .writeSelect(writeSelect), .opcode(opcode),
		.latchOperands(latchOperands), .executeStrobe(executeStrobe),
		.commitFlags(commitFlags), .memAddr(memAddr),
		.memWrite(memWrite), .memRead(memRead)
	);

	registerFile u_registerFile (
		.Clock_pin(Clock_pin), .rstN(rstN),
		.readIndexA(readIndexA), .readIndexB(readIndexB), .writeIndex(writeIndex),
		.writeEnable(regWrite), .writeData(writeData),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	// k comes straight from the fetched word, valid while operands latch
	aluUnit u_aluUnit (
		.Clock_pin(Clock_pin), .rstN(rstN), .opcode(opcode),
		.operandA(readDataA), .operandB(readDataB), .shiftAmount(instr[1:0]),
		.latchOperands(latchOperands), .executeStrobe(executeStrobe),
		.commitFlags(commitFlags), .result(result), .flags(flags)
	);

	dataMemory #(.DataDepth(DataDepth)) u_dataMemory (
		.Clock_pin(Clock_pin), .rstN(rstN), .memAddr(memAddr),
		.storeData(readDataB), .memWrite(memWrite), .memRead(memRead),
		.switches(switches), .loadData(loadData), .display(display)
	);

	programMemory #(.ProgramDepth(ProgramDepth)) u_programMemory (
		.Clock_pin(Clock_pin), .fetchAddr(pc), .instr(instr),
		.loadWrite(progWrite), .loadAddr(progAddr), .loadData(progData)
	);

endmodule

/* testbench/tbRisc621.sv */
`timescale 1ns/1ps

module tbRisc621
	import risc621Pkg::*;
;

	// ----------------------------------------
	// Run length
	// ----------------------------------------
	localparam int clockPeriod  = 40;
	localparam int runCount     = 9;   // Program loads over all tests
	localparam int cyclesPerRun = 200; // Longest run is the logic test, about 145
	localparam int watchdogTime = (runCount * cyclesPerRun + 100) * clockPeriod;

	logic       Clock_pin;
	logic       rstN;
	logic [4:0] switches;
	logic [7:0] display;
	logic       progWrite;
	word_t      progAddr;
	word_t      progData;

	word_t prog [$]; // Words of the current test program
	int    errors;
	int    passCount;
	int    failCount;

	risc621 #(.ProgramDepth(256), .DataDepth(256)) u_risc621 (
		.Clock_pin(Clock_pin), .rstN(rstN), .switches(switches), .display(display),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData)
	);

	always #(clockPeriod / 2) Clock_pin = ~Clock_pin;

	// ----------------------------------------
	// Assembler and reference model
	// ----------------------------------------
	function automatic word_t assemble(opcode_t op, regIndex_t ri, regIndex_t rj,
		shiftAmount_t k);
		return {op, ri, rj, k};
	endfunction

	// Condition in IR[5:2], target register in IR[1:0]
	function automatic word_t jumpWord(jumpCond_t c, regIndex_t target);
		return {JMP, c, target};
	endfunction

	function automatic word_t modelAlu(opcode_t op, word_t a, word_t b, shiftAmount_t k);
		word_t r;
		r = a;
		case (op)
			ADD:  r = a + b;
			SUB:  r = a - b;
			ADDC: r = a + word_t'(k);
			SUBC: r = a - word_t'(k);
			NOT:  r = ~a;
			AND:  r = a & b;
			OR:   r = a | b;
			XOR:  r = a ^ b;
			SHLL: r = a << k;
			SHRL: r = a >> k;
			SHLA:
			begin
				r     = a << k;
				r[11] = a[11]; // Sign bit held
			end
			SHRA: for (int i = 0; i < k; i++) r = {r[11], r[11:1]};
			ROTL: for (int i = 0; i < k; i++) r = {r[10:0], r[11]};
			ROTR: for (int i = 0; i < k; i++) r = {r[0], r[11:1]};
			CPY:  r = b;
			default: r = a;
		endcase
		return r;
	endfunction

	// ----------------------------------------
	// Drive and check helpers
	// ----------------------------------------
	// Holds reset, writes prog from 0 and the self-jump at 0xFF, then releases
	task automatic loadProgram();
		@(posedge Clock_pin);
		rstN      <= 1'b0;
		progWrite <= 1'b1;
		foreach (prog[i])
		begin
			progAddr <= word_t'(i);
			progData <= prog[i];
			@(posedge Clock_pin);
		end
		progAddr  <= 12'h0FF; // Jump to R3 = 0xFFF lands here
		progData  <= jumpWord(JU, 2'd3);
		@(posedge Clock_pin);
		progWrite <= 1'b0;
		repeat (3) @(posedge Clock_pin);
		rstN <= 1'b1;
	endtask

	// Count rising edges, then sample on the falling edge
	task automatic waitCycles(int n);
		repeat (n) @(posedge Clock_pin);
		@(negedge Clock_pin);
	endtask

	task automatic checkDisplay(logic [7:0] expected);
		if (display !== expected)
		begin
			$display("Fail t=%0t display expected %h got %h", $time, expected, display);
			errors++;
		end
	endtask

	task automatic checkWord(string name, word_t expected, word_t actual);
		if (actual !== expected)
		begin
			$display("Fail t=%0t %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic reportTest(string name, int errorsAtStart);
		if (errors == errorsAtStart)
		begin
			passCount++;
			$display("Test %s passed", name);
		end
		else
		begin
			failCount++;
			$display("Test %s failed", name);
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic testReset();
		int start;
		start = errors;
		prog.delete();
		prog.push_back(jumpWord(JU, 2'd3)); // R3 is 0, so jumps to itself
		loadProgram();
		@(negedge Clock_pin);
		checkWord("pc", 12'h000, u_risc621.pc); // Still 0 until first FETCH ends
		waitCycles(4 * (1 + 2));
		checkDisplay(8'h00);
		reportTest("reset", start);
	endtask

	task automatic testArithmetic();
		int    start;
		word_t a;
		word_t b;
		start = errors;
		prog.delete();
		prog.push_back(assemble(SUBC, 2'd3, 2'd0, 2'd1)); // I/O address 0xFFF
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(SUBC, 2'd1, 2'd0, 2'd2));
		prog.push_back(assemble(ADD, 2'd0, 2'd1, 2'd0));
		prog.push_back(assemble(SUB, 2'd1, 2'd0, 2'd0));
		prog.push_back(assemble(ST, 2'd1, 2'd3, 2'd0));
		prog.push_back(jumpWord(JU, 2'd3));
		a = modelAlu(ADDC, modelAlu(ADDC, 12'h0, 12'h0, 2'd3), 12'h0, 2'd3);
		b = modelAlu(SUBC, 12'h0, 12'h0, 2'd2);
		a = modelAlu(ADD, a, b, 2'd0);
		b = modelAlu(SUB, b, a, 2'd0);
		loadProgram();
		waitCycles(4 * (8 + 2));
		checkDisplay(b[7:0]);
		reportTest("arithmetic", start);
	endtask

	task automatic testLogicShift();
		opcode_t      ops [10];
		shiftAmount_t ks [10];
		regIndex_t    rj;
		word_t        v;
		word_t        r1;
		word_t        r2;
		int           start;
		ops   = '{NOT, AND, OR, XOR, SHLL, SHRL, SHLA, SHRA, ROTL, ROTR};
		ks    = '{2'd0, 2'd0, 2'd0, 2'd0, 2'd1, 2'd2, 2'd1, 2'd3, 2'd2, 2'd1};
		start = errors;
		prog.delete();
		prog.push_back(assemble(SUBC, 2'd3, 2'd0, 2'd1));
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(SHLL, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(ROTR, 2'd0, 2'd0, 2'd1));
		prog.push_back(assemble(SUBC, 2'd1, 2'd0, 2'd3)); // Second operands
		prog.push_back(assemble(ADDC, 2'd2, 2'd0, 2'd3));
		for (int j = 0; j < 10; j++)
		begin
			rj = (ops[j] == OR) ? 2'd2 : 2'd1;
			prog.push_back(assemble(ops[j], 2'd0, rj, ks[j]));
			prog.push_back(assemble(ST, 2'd0, 2'd3, 2'd0)); // Show R0
		end
		prog.push_back(jumpWord(JU, 2'd3));
		v  = modelAlu(ADDC, 12'h0, 12'h0, 2'd3);
		v  = modelAlu(SHLL, v, 12'h0, 2'd3);
		v  = modelAlu(ADDC, v, 12'h0, 2'd3);
		v  = modelAlu(ROTR, v, 12'h0, 2'd1);
		r1 = modelAlu(SUBC, 12'h0, 12'h0, 2'd3);
		r2 = modelAlu(ADDC, 12'h0, 12'h0, 2'd3);
		loadProgram();
		waitCycles(4 * 9); // First store is instruction 8
		for (int j = 0; j < 10; j++)
		begin
			v = modelAlu(ops[j], v, (ops[j] == OR) ? r2 : r1, ks[j]);
			checkDisplay(v[7:0]);
			if (j < 9)
				waitCycles(8); // Next op and its store
		end
		reportTest("logic and shifts", start);
	endtask

	task automatic testDataMemory();
		int    start;
		word_t v;
		start = errors;
		prog.delete();
		prog.push_back(assemble(SUBC, 2'd3, 2'd0, 2'd1));
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(SHLL, 2'd0, 2'd0, 2'd3));
		prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd2));
		prog.push_back(assemble(ADDC, 2'd1, 2'd0, 2'd2)); // Base address 2
		prog.push_back(assemble(ST, 2'd0, 2'd1, 2'd1));   // RAM word 3
		prog.push_back(assemble(XOR, 2'd0, 2'd0, 2'd0));  // Clear R0
		prog.push_back(assemble(LD, 2'd0, 2'd1, 2'd1));
		prog.push_back(assemble(ST, 2'd0, 2'd3, 2'd0));
		prog.push_back(jumpWord(JU, 2'd3));
		v = modelAlu(SHLL, modelAlu(ADDC, 12'h0, 12'h0, 2'd3), 12'h0, 2'd3);
		v = modelAlu(ADDC, v, 12'h0, 2'd2);
		loadProgram();
		waitCycles(4 * (10 + 2));
		checkDisplay(v[7:0]);
		reportTest("data memory", start);
	endtask

	task automatic testSwitches();
		int         start;
		logic [4:0] sw;
		start = errors;
		sw    = 5'($urandom_range(31, 1)); // Nonzero, unlike the reset display
		@(posedge Clock_pin);
		switches <= sw;
		prog.delete();
		prog.push_back(assemble(SUBC, 2'd3, 2'd0, 2'd1));
		prog.push_back(assemble(LD, 2'd0, 2'd3, 2'd0));
		prog.push_back(assemble(ST, 2'd0, 2'd3, 2'd0));
		prog.push_back(jumpWord(JU, 2'd3));
		loadProgram();
		waitCycles(4 * (4 + 2));
		checkDisplay({3'b000, sw}); // Zero-extended switch value
		reportTest("switches", start);
	endtask

	task automatic testJumps();
		jumpCond_t   conds [4];
		logic [12:0] wide;
		logic        zFlag;
		logic        cFlag;
		logic        taken;
		word_t       markerNot;
		word_t       markerTaken;
		int          start;
		conds       = '{JZ1, JZ0, JC1, JC0};
		markerNot   = modelAlu(ADDC, 12'h0, 12'h0, 2'd3);
		markerTaken = modelAlu(SHLL, markerNot, 12'h0, 2'd2);
		start       = errors;
		for (int t = 0; t < 4; t++)
		begin
			prog.delete();
			prog.push_back(assemble(SUBC, 2'd3, 2'd0, 2'd1));
			prog.push_back(assemble(ADDC, 2'd0, 2'd0, 2'd3)); // Not-taken marker
			prog.push_back(assemble(ADDC, 2'd2, 2'd0, 2'd3));
			prog.push_back(assemble(ADDC, 2'd1, 2'd0, 2'd1));
			// Z group subtracts to zero, C group adds 1 + 0xFFF
			if (t < 2)
				prog.push_back(assemble(SUB, 2'd1, 2'd1, 2'd0));
			else
				prog.push_back(assemble(ADD, 2'd1, 2'd3, 2'd0));
			prog.push_back(assemble(CPY, 2'd1, 2'd0, 2'd0));  // Flags untouched from here
			prog.push_back(assemble(SHLL, 2'd1, 2'd0, 2'd2)); // Taken marker
			prog.push_back(assemble(SHLL, 2'd2, 2'd0, 2'd2)); // Target 12
			prog.push_back(jumpWord(conds[t], 2'd2));
			prog.push_back(assemble(ST, 2'd0, 2'd3, 2'd0));
			prog.push_back(jumpWord(JU, 2'd3));
			prog.push_back(assemble(NOP, 2'd0, 2'd0, 2'd0));
			prog.push_back(assemble(ST, 2'd1, 2'd3, 2'd0));   // Address 12
			prog.push_back(jumpWord(JU, 2'd3));
			if (t < 2)
				wide = {1'b0, 12'h001} - {1'b0, 12'h001};
			else
				wide = {1'b0, 12'h001} + {1'b0, 12'hFFF};
			cFlag = wide[12];
			zFlag = (wide[11:0] == 12'h000);
			case (conds[t])
				JZ1:     taken = zFlag;
				JZ0:     taken = !zFlag;
				JC1:     taken = cFlag;
				default: taken = !cFlag;
			endcase
			loadProgram();
			waitCycles(4 * (11 + 2)); // Both paths run 11 instructions
			checkDisplay(taken ? markerTaken[7:0] : markerNot[7:0]);
		end
		reportTest("jumps", start);
	endtask

	// ----------------------------------------
	// Sequence and watchdog
	// ----------------------------------------
	initial
	begin
		Clock_pin = 1'b0;
		rstN      = 1'b0;
		switches  = '0;
		progWrite = 1'b0;
		progAddr  = '0;
		progData  = '0;
		errors    = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(61));
		testReset();
		testArithmetic();
		testLogicShift();
		testDataMemory();
		testSwitches();
		testJumps();
		$display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(watchdogTime);
		$display("Watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* risc621.f */
source/risc621Pkg.sv
source/programMemory.sv
source/registerFile.sv
source/dataMemory.sv
source/aluUnit.sv
source/controlUnit.sv
source/risc621.sv
testbench/tbRisc621.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbRisc621
FILELIST  = risc621.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJDIR)
